// ==== div_msg_pkg.sv ====
// divider message types
// request and response payloads plus the function codes, shared with the testbench
package div_msg_pkg;

  //----------------------------------------------------------
  // widths
  //----------------------------------------------------------

  // operand width, the top level passes it down as data_w
  localparam int unsigned DIV_DATA_W = 32;

  //----------------------------------------------------------
  // function codes
  //----------------------------------------------------------

  // signed uses two's complement operands, unsigned takes raw bits
  typedef enum logic {
    DIV_FN_SIGNED   = 1'b0,
    DIV_FN_UNSIGNED = 1'b1
  } div_fn_t;

  //----------------------------------------------------------
  // messages
  //----------------------------------------------------------

  // request: function, dividend, divisor (65 bits)
  typedef struct packed {
    div_fn_t               fn;
    logic [DIV_DATA_W-1:0] a;
    logic [DIV_DATA_W-1:0] b;
  } div_req_t;

  // response: remainder in the upper word, quotient in the lower word
  typedef struct packed {
    logic [DIV_DATA_W-1:0] remainder;
    logic [DIV_DATA_W-1:0] quotient;
  } div_resp_t;

endpackage

// ==== div_ctrl_pkg.sv ====
// divider control types
// controller state encoding and the strobe bundle sent to the data blocks
package div_ctrl_pkg;

  //----------------------------------------------------------
  // controller state
  //----------------------------------------------------------

  // idle waits for a request
  // calc runs one shift-subtract per cycle
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

  //----------------------------------------------------------
  // strobes from the controller
  //----------------------------------------------------------

  // load: capture a new request into counter, sign flags and datapath
  // step: one iteration of the divide loop
  // never both in the same cycle
  typedef struct packed {
    logic load;
    logic step;
  } div_ctrl_t;

endpackage

// ==== div_ctrl.sv ====
// divider controller
// three-state FSM, owns both valid/ready handshakes and issues load/step strobes
module div_ctrl import div_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      divreq_val,
  output logic      divreq_rdy,
  output logic      divresp_val,
  input  logic      divresp_rdy,
  input  logic      last_step,
  output div_ctrl_t ctrl
);

  div_state_t state;
  div_state_t state_next;

  //----------------------------------------------------------
  // handshake and strobes
  //----------------------------------------------------------

  // ready only while nothing is in flight
  assign divreq_rdy  = (state == DIV_IDLE);
  // response valid for the whole done state
  assign divresp_val = (state == DIV_DONE);

  // load lands in the accept cycle itself
  assign ctrl.load = (state == DIV_IDLE) && divreq_val;
  // one iteration per calc cycle
  assign ctrl.step = (state == DIV_CALC);

  //----------------------------------------------------------
  // next state
  //----------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      DIV_IDLE: begin
        // request transfers when valid meets our ready
        if (divreq_val) begin
          state_next = DIV_CALC;
        end
      end
      DIV_CALC: begin
        // counter at zero means this step is the last one
        if (ctrl.step && last_step) begin
          state_next = DIV_DONE;
        end
      end
      DIV_DONE: begin
        // back to idle once the consumer takes the result
        if (divresp_rdy) begin
          state_next = DIV_IDLE;
        end
      end
      default: begin
        state_next = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // the two handshakes never overlap
  a_no_req_resp_overlap: assert property (@(posedge clk) disable iff (reset)
    !(divreq_rdy && divresp_val))
    else $error("div_ctrl: divreq_rdy and divresp_val high together");

  // a load outside idle would clobber an operation in flight
  a_load_in_idle: assert property (@(posedge clk) disable iff (reset)
    ctrl.load |-> (state == DIV_IDLE))
    else $error("div_ctrl: load strobe outside idle");

  // a response is never withdrawn before it is taken
  a_resp_held: assert property (@(posedge clk) disable iff (reset)
    (divresp_val && !divresp_rdy) |=> divresp_val)
    else $error("div_ctrl: divresp_val dropped without divresp_rdy");

endmodule

// ==== div_step_counter.sv ====
// divider step counter
// counts the remaining iterations and flags the final one
module div_step_counter import div_ctrl_pkg::*; #(
  parameter int unsigned data_w = 32
) (
  input  logic      clk,
  input  logic      reset,
  input  div_ctrl_t ctrl,
  output logic      last_step
);

  // enough bits to hold data_w-1
  localparam int unsigned cnt_w = $clog2(data_w);

  logic [cnt_w-1:0] count;

  //----------------------------------------------------------
  // counter
  //----------------------------------------------------------

  // load starts at data_w-1 so that data_w steps run in total
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ctrl.load) begin
      count <= cnt_w'(data_w - 1);
    end else if (ctrl.step) begin
      count <= count - 1'b1;
    end
  end

  // combinational, the controller leaves calc on this cycle
  assign last_step = (count == '0);

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // the final step must be followed by done, not by another step
  a_no_extra_step: assert property (@(posedge clk) disable iff (reset)
    (ctrl.step && last_step) |=> !ctrl.step)
    else $error("div_step_counter: step issued after the final step");

endmodule

// ==== div_sign_fixup.sv ====
// divider sign handling
// operand magnitudes at load, stored sign flags, final quotient/remainder correction
module div_sign_fixup import div_msg_pkg::*, div_ctrl_pkg::*; #(
  parameter int unsigned data_w = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  div_ctrl_t         ctrl,
  input  div_req_t          divreq,
  output logic [data_w-1:0] a_mag,
  output logic [data_w-1:0] b_mag,
  input  logic [data_w-1:0] quot_raw,
  input  logic [data_w-1:0] rem_raw,
  output div_resp_t         divresp
);

  logic signed_req;
  logic a_neg;
  logic b_neg;
  logic quot_neg;
  logic rem_neg;
  logic [data_w-1:0] quot_fix;
  logic [data_w-1:0] rem_fix;

  //----------------------------------------------------------
  // operand magnitudes
  //----------------------------------------------------------

  assign signed_req = (divreq.fn == DIV_FN_SIGNED);

  // msb only counts as a sign for signed requests
  assign a_neg = signed_req && divreq.a[data_w-1];
  assign b_neg = signed_req && divreq.b[data_w-1];

  // two's complement negate, most negative maps onto itself
  // which is still the right unsigned magnitude
  assign a_mag = a_neg ? (~divreq.a + 1'b1) : divreq.a;
  assign b_mag = b_neg ? (~divreq.b + 1'b1) : divreq.b;

  //----------------------------------------------------------
  // sign flags
  //----------------------------------------------------------

  // captured with the operands, held through calc and done
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (ctrl.load) begin
      // quotient negative when the operand signs differ
      quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
    end
  end

  //----------------------------------------------------------
  // result correction
  //----------------------------------------------------------

  assign quot_fix = quot_neg ? (~quot_raw + 1'b1) : quot_raw;
  assign rem_fix  = rem_neg ? (~rem_raw + 1'b1) : rem_raw;

  assign divresp = '{remainder: rem_fix, quotient: quot_fix};

endmodule

// ==== div_remainder_dpath.sv ====
// divider datapath
// remainder/quotient shift register and divisor, one restoring step per strobe
module div_remainder_dpath import div_ctrl_pkg::*; #(
  parameter int unsigned data_w = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  div_ctrl_t         ctrl,
  input  logic [data_w-1:0] a_mag,
  input  logic [data_w-1:0] b_mag,
  output logic [data_w-1:0] quot_raw,
  output logic [data_w-1:0] rem_raw
);

  // two words plus a guard bit so the subtract sign is visible
  localparam int unsigned acc_w = 2 * data_w + 1;

  // upper half holds the partial remainder
  // lower half starts as the dividend and fills with quotient bits
  logic [acc_w-1:0] acc;
  // divisor lined up with the upper half
  logic [acc_w-1:0] divisor;

  logic [acc_w-1:0] acc_shift;
  logic [acc_w-1:0] acc_diff;
  logic             diff_neg;
  logic [acc_w-1:0] acc_next;

  //----------------------------------------------------------
  // restoring step
  //----------------------------------------------------------

  // bring the next dividend bit into the remainder
  assign acc_shift = acc << 1;
  assign acc_diff  = acc_shift - divisor;

  // guard bit set means the divisor did not fit
  assign diff_neg = acc_diff[acc_w-1];

  always_comb begin
    if (diff_neg) begin
      // restore, shifted lsb is already the zero quotient bit
      acc_next = acc_shift;
    end else begin
      // keep the difference and record a one
      acc_next = {acc_diff[acc_w-1:1], 1'b1};
    end
  end

  //----------------------------------------------------------
  // registers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      acc     <= {{(data_w + 1){1'b0}}, a_mag};
      divisor <= {1'b0, b_mag, {data_w{1'b0}}};
    end else if (ctrl.step) begin
      acc <= acc_next;
    end
  end

  // final after the last step, read from the first done cycle
  assign quot_raw = acc[data_w-1:0];
  assign rem_raw  = acc[2*data_w-1:data_w];

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // a load mid-step would mix two operations in the register
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.load && ctrl.step))
    else $error("div_remainder_dpath: load and step in the same cycle");

endmodule

// ==== int_div_iterative.sv ====
// iterative integer divider
// 32-step restoring divide behind valid/ready request and response ports
module int_div_iterative import div_msg_pkg::*, div_ctrl_pkg::*; #(
  parameter int unsigned data_w = DIV_DATA_W
) (
  input  logic      clk,
  input  logic      reset,
  input  div_req_t  divreq,
  input  logic      divreq_val,
  output logic      divreq_rdy,
  output div_resp_t divresp,
  output logic      divresp_val,
  input  logic      divresp_rdy
);

  // strobes from the controller to every data block
  div_ctrl_t ctrl;
  logic      last_step;

  // operand magnitudes into the datapath
  logic [data_w-1:0] a_mag;
  logic [data_w-1:0] b_mag;

  // unsigned result back to the sign block
  logic [data_w-1:0] quot_raw;
  logic [data_w-1:0] rem_raw;

  //----------------------------------------------------------
  // control
  //----------------------------------------------------------

  div_ctrl ctrl0 (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .divresp_rdy (divresp_rdy),
    .last_step   (last_step),
    .ctrl        (ctrl)
  );

  div_step_counter #(.data_w(data_w)) counter0 (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .last_step (last_step)
  );

  //----------------------------------------------------------
  // data
  //----------------------------------------------------------

  div_sign_fixup #(.data_w(data_w)) sign0 (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .divreq   (divreq),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .quot_raw (quot_raw),
    .rem_raw  (rem_raw),
    .divresp  (divresp)
  );

  div_remainder_dpath #(.data_w(data_w)) dpath0 (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .quot_raw (quot_raw),
    .rem_raw  (rem_raw)
  );

endmodule

// ==== int_div_iterative_tb.sv ====
// testbench for the iterative divider
// reference divide, queued expectations, response checks for value, hold and latency
module int_div_iterative_tb import div_msg_pkg::*; ();

  localparam int data_w = DIV_DATA_W;
  // edges from acceptance to the first edge that sees divresp_val
  localparam int latency_edges = 33;
  localparam int wait_limit = 200;

  logic      clk;
  logic      reset;
  div_req_t  divreq;
  logic      divreq_val;
  logic      divreq_rdy;
  div_resp_t divresp;
  logic      divresp_val;
  logic      divresp_rdy;

  int          errors = 0;
  int          checked = 0;
  int          accepted = 0;
  int          sent = 0;
  int          cycle = 0;
  int          first_val = 0;
  logic        busy = 1'b0;
  logic        prev_wait = 1'b0;
  div_resp_t   held;
  string       test_name = "reset";
  logic [31:0] seed = 32'h5e9f;

  // expected results and acceptance edges, in request order
  div_resp_t exp_q[$];
  int        acc_q[$];

  int_div_iterative #(.data_w(data_w)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .divreq      (divreq),
    .divreq_val  (divreq_val),
    .divreq_rdy  (divreq_rdy),
    .divresp     (divresp),
    .divresp_val (divresp_val),
    .divresp_rdy (divresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //----------------------------------------------------------
  // reference model and helpers
  //----------------------------------------------------------

  // truncating divide on magnitudes, zero divisor gives all ones and the dividend
  function automatic div_resp_t ref_div(div_req_t req);
    logic              a_neg;
    logic              b_neg;
    logic [data_w-1:0] a_abs;
    logic [data_w-1:0] b_abs;
    div_resp_t         res;
    a_neg = (req.fn == DIV_FN_SIGNED) && req.a[data_w-1];
    b_neg = (req.fn == DIV_FN_SIGNED) && req.b[data_w-1];
    a_abs = a_neg ? (0 - req.a) : req.a;
    b_abs = b_neg ? (0 - req.b) : req.b;
    if (b_abs == '0) begin
      res.quotient  = '1;
      res.remainder = a_abs;
    end else begin
      res.quotient  = a_abs / b_abs;
      res.remainder = a_abs % b_abs;
    end
    // quotient negative on differing signs, remainder follows the dividend
    if (a_neg != b_neg) begin
      res.quotient = 0 - res.quotient;
    end
    if (a_neg) begin
      res.remainder = 0 - res.remainder;
    end
    return res;
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_resp(string name, div_resp_t exp, div_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected rem %h quo %h, actual rem %h quo %h",
               name, exp.remainder, exp.quotient, act.remainder, act.quotient);
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (act != exp) begin
      errors++;
      $display("Error %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("%0d errors, %0d responses checked", errors, checked);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    errors++;
    $display("timeout in %s: %s, controller in %s", test_name, what, dut0.ctrl0.state.name());
    finish_run();
  endtask

  //----------------------------------------------------------
  // stimulus tasks, called on a rising edge
  //----------------------------------------------------------

  task automatic offer_req(div_fn_t fn, logic [31:0] a, logic [31:0] b);
    divreq     <= '{fn: fn, a: a, b: b};
    divreq_val <= 1'b1;
  endtask

  // valid stays high after the handshake edge, so calls chain back to back
  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > wait_limit) begin
        report_timeout("request was never accepted");
      end
    end while (!divreq_rdy);
    sent++;
  endtask

  task automatic send_div(div_fn_t fn, logic [31:0] a, logic [31:0] b);
    offer_req(fn, a, b);
    wait_accept();
  endtask

  task automatic wait_resp();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > wait_limit) begin
        report_timeout("divresp_val never rose");
      end
    end while (!divresp_val);
  endtask

  // polled on falling edges, where the monitor has finished its updates
  task automatic drain();
    int n;
    n = 0;
    divreq_val <= 1'b0;
    do begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        report_timeout("outstanding responses never arrived");
      end
    end while (exp_q.size() != 0 || divresp_val);
    @(posedge clk);
  endtask

  task automatic rand_req(output div_fn_t fn, output logic [31:0] a, output logic [31:0] b);
    seed = lcg_next(seed);
    a    = seed;
    seed = lcg_next(seed);
    b    = seed;
    seed = lcg_next(seed);
    // shrink the divisor now and then so quotients vary in size
    b  = b >> seed[28:24];
    fn = seed[31] ? DIV_FN_UNSIGNED : DIV_FN_SIGNED;
  endtask

  //----------------------------------------------------------
  // monitor: handshakes, hold, compare against queue
  //----------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (busy && divreq_rdy) begin
        errors++;
        $display("%s: divreq_rdy high while a division is in flight", test_name);
      end
      if (divreq_val && divreq_rdy) begin
        exp_q.push_back(ref_div(divreq));
        acc_q.push_back(cycle);
        accepted++;
        busy = 1'b1;
      end
      if (divresp_val && !prev_wait) begin
        first_val = cycle;
      end
      // payload frozen while the consumer stalls
      if (divresp_val && prev_wait) begin
        check_resp({test_name, " hold"}, held, divresp);
      end
      if (divresp_val && divresp_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: response arrived with no request outstanding", test_name);
        end else begin
          check_resp(test_name, exp_q.pop_front(), divresp);
          check_latency(test_name, latency_edges, first_val - acc_q.pop_front());
          checked++;
        end
        busy = 1'b0;
      end
      prev_wait = divresp_val && !divresp_rdy;
      held      = divresp;
    end
    cycle = cycle + 1;
  end

  //----------------------------------------------------------
  // test sequence
  //----------------------------------------------------------

  initial begin
    div_fn_t     fn;
    logic [31:0] a;
    logic [31:0] b;
    reset       = 1'b1;
    divreq      = '0;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("reset divresp_val", 1'b0, divresp_val);
    check_flag("reset divreq_rdy", 1'b1, divreq_rdy);

    // sign combinations, overflow case, zero dividend, zero divisor
    test_name = "directed";
    send_div(DIV_FN_UNSIGNED, 32'd7, 32'd2);
    send_div(DIV_FN_UNSIGNED, 32'hffff_fff9, 32'd2);
    send_div(DIV_FN_SIGNED, 32'd7, 32'd2);
    send_div(DIV_FN_SIGNED, -32'sd7, 32'd2);
    send_div(DIV_FN_SIGNED, 32'd7, -32'sd2);
    send_div(DIV_FN_SIGNED, -32'sd7, -32'sd2);
    send_div(DIV_FN_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_div(DIV_FN_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_div(DIV_FN_SIGNED, 32'd0, 32'd5);
    send_div(DIV_FN_UNSIGNED, 32'd0, 32'd5);
    send_div(DIV_FN_SIGNED, 32'd7, 32'd0);
    send_div(DIV_FN_SIGNED, -32'sd7, 32'd0);
    send_div(DIV_FN_UNSIGNED, 32'hffff_fff9, 32'd0);
    drain();

    // stalled consumer, a second request waits behind the held response
    test_name = "backpressure";
    for (int i = 0; i < 4; i++) begin
      divresp_rdy <= 1'b0;
      rand_req(fn, a, b);
      send_div(fn, a, b);
      rand_req(fn, a, b);
      offer_req(fn, a, b);
      wait_resp();
      seed = lcg_next(seed);
      repeat (seed[27:24] + 1) @(posedge clk);
      divresp_rdy <= 1'b1;
      wait_accept();
      drain();
    end

    test_name = "random";
    for (int i = 0; i < 200; i++) begin
      rand_req(fn, a, b);
      send_div(fn, a, b);
    end
    drain();

    if (accepted != sent || checked != sent) begin
      errors++;
      $display("%0d requests sent, %0d accepted, %0d responses checked", sent, accepted, checked);
    end
    finish_run();
  end

endmodule

// ==== verilog.f ====
div_msg_pkg.sv
div_ctrl_pkg.sv
div_ctrl.sv
div_step_counter.sv
div_sign_fixup.sv
div_remainder_dpath.sv
int_div_iterative.sv
int_div_iterative_tb.sv

// ==== Bender.yml ====
package:
  name: int_div_iterative

sources:
  - div_msg_pkg.sv
  - div_ctrl_pkg.sv
  - div_ctrl.sv
  - div_step_counter.sv
  - div_sign_fixup.sv
  - div_remainder_dpath.sv
  - int_div_iterative.sv
  - target: test
    files:
      - int_div_iterative_tb.sv
